// ==== bench/hazardDetect_checker.sv ====
`timescale 1ns/1ps
module hazardDetect_checker (
    input logic                  clk,
    input logic                  rst,
    input issuePkg::hazardView_t hazardView,
    input issuePkg::issueSlot_t  issue,
    input logic                  stall
);
    import issuePkg::*;

    logic [4:0] op;
    logic       readsRs;
    logic       readsRt;
    logic       srcClash;

    function automatic logic pendingIn(input hazardView_t v, input logic [2:0] r);
        return (v.d.regWrt && (v.d.wrtReg == r)) || (v.x.regWrt && (v.x.wrtReg == r))
            || (v.m.regWrt && (v.m.wrtReg == r));
    endfunction

    assign op = issue.inst.r.op;
    // lbi, halt, nop read nothing
    assign readsRs = !((op == 5'b11000) || (op == 5'b00000) || (op == 5'b00001));
    // stores, arith and set also read rt
    assign readsRt = (op == 5'b10000) || (op == 5'b10011) || (op[4:1] == 4'b1101)
                  || (op[4:2] == 3'b111);
    assign srcClash = (readsRs && pendingIn(hazardView, issue.inst.r.rs))
                   || (readsRt && pendingIn(hazardView, issue.inst.r.rt));

    noIssueWhileCtrl: assert property (@(posedge clk) disable iff (rst)
        hazardView.ctrlBusy |-> !issue.valid) else $error("issue while control in flight");
    noIssueOnClash: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !srcClash) else $error("issued source has a pending writer");
    stallMeansBubble: assert property (@(posedge clk) disable iff (rst)
        stall |-> !issue.valid) else $error("issue valid during stall");

endmodule

// combinational hazard unit sampled on the top-level clock
bind issueFrontEnd hazardDetect_checker hazardChk (
    .clk        (clk),
    .rst        (rst),
    .hazardView (hazardView),
    .issue      (issue),
    .stall      (stall)
);

// ==== bench/issueFrontEnd_tb.sv ====
`timescale 1ns/1ps
module issueFrontEnd_tb;
    import issuePkg::*;

    logic                clk;
    logic                rst;
    loadReq_t            load;
    logic                start;
    retireRec_t          retire;
    logic [cntWidth-1:0] retiredCount;
    logic                done;

    // program image and expected retire pcs from the model
    logic [instWidth-1:0] prog [];
    int                   expPc [$];

    // retire monitor state
    int          cycle = 0;
    int          retIdx;
    int          doneCount;
    int          lastRetire;
    int          ctrlTarget;
    int          lastWrite [8];
    logic        lastWasCtrl;
    logic        armed = 1'b0;
    // watchdog limit in cycles grows with each program
    int          budget = 40;
    logic [31:0] seedDummy;

    issueFrontEnd u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic failWith(input string what);
        $display("error at %0t: %s", $time, what);
        stopRun();
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stopRun();
        end
    endtask

    // 0 halt/nop, 1 lbi, 2 store, 3 arith/set, 4 control, 5 default
    function automatic int opClass(input logic [4:0] op);
        if ((op == 5'b00000) || (op == 5'b00001)) return 0;
        if (op == 5'b11000) return 1;
        if ((op == 5'b10000) || (op == 5'b10011)) return 2;
        if ((op[4:1] == 4'b1101) || (op[4:2] == 3'b111)) return 3;
        if ((op[4:2] == 3'b001) || (op[4:2] == 3'b011)) return 4;
        return 5;
    endfunction

    task automatic checkRetire();
        logic [15:0] word;
        logic [2:0]  rs;
        logic [2:0]  rt;
        int          cls;
        word = retire.inst;
        rs   = word[10:8];
        rt   = word[7:5];
        cls  = opClass(word[15:11]);
        if (!armed) failWith("retire strobe outside a started program");
        if (retIdx >= expPc.size()) failWith("more retires than the program model holds");
        compare("retire.pc", 32'(retire.pc), expPc[retIdx]);
        compare("retire.inst", 32'(word), 32'(prog[expPc[retIdx]]));
        if (lastWasCtrl) begin
            if (cycle - lastRetire < 5) failWith("retire under 5 cycles after a control retire");
            compare("retire.pc after control", 32'(retire.pc), ctrlTarget);
        end
        // everything but halt, nop and lbi reads rs
        if ((cls >= 2) && (cycle - lastWrite[rs] < 4)) begin
            failWith("rs reader retired under 4 cycles after its writer");
        end
        if (((cls == 2) || (cls == 3)) && (cycle - lastWrite[rt] < 4)) begin
            failWith("rt reader retired under 4 cycles after its writer");
        end
        // lbi writes rs, arith/set write rdLow, default writes rt
        if (cls == 1) lastWrite[rs] = cycle;
        if (cls == 3) lastWrite[word[4:2]] = cycle;
        if (cls == 5) lastWrite[rt] = cycle;
        lastWasCtrl = (cls == 4);
        ctrlTarget  = (int'(retire.pc) + 1 + int'(word[7:0])) % 256;
        lastRetire  = cycle;
        retIdx++;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        cycle++;
        if (retire.valid) checkRetire();
        if (done) begin
            if (!armed) failWith("done strobe outside a started program");
            compare("retire.valid at done", 32'(retire.valid), 1);
            compare("retires at done", retIdx, expPc.size());
            compare("retiredCount", 32'(retiredCount), expPc.size());
            doneCount++;
            armed = 1'b0;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (cycle > budget) begin
                $display("watchdog: no done strobe within %0d cycles", budget);
                stopRun();
            end
        end
    end

    task automatic runProgram();
        int         len;
        int         pc;
        logic [4:0] op;
        logic [15:0] w;
        len = 40 + int'($urandom % 41);
        budget += 20 * len;
        prog = new[len];
        // random body with the halt only in the last word
        for (int a = 0; a < len; a++) begin
            op = 5'($urandom);
            if (a == len - 1) op = 5'b00000;
            else if (op == 5'b00000) op = 5'b00001;
            w = {op, 11'($urandom)};
            // forward displacement that lands at most on the halt
            if (opClass(op) == 4) w[7:0] = 8'($urandom % (len - a - 1));
            prog[a] = w;
            @(posedge clk);
            load <= '{valid: 1'b1, addr: 8'(a), data: w};
        end
        // walk the program taking every control op
        expPc.delete();
        pc = 0;
        expPc.push_back(pc);
        while (prog[pc][15:11] != 5'b00000) begin
            if (opClass(prog[pc][15:11]) == 4) pc = pc + 1 + int'(prog[pc][7:0]);
            else pc++;
            expPc.push_back(pc);
        end
        foreach (lastWrite[r]) lastWrite[r] = -100;
        retIdx      = 0;
        doneCount   = 0;
        lastWasCtrl = 1'b0;
        armed       = 1'b1;
        @(posedge clk);
        load  <= '0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait (doneCount == 1);
        // idle tail catches stray strobes
        repeat (10) @(posedge clk);
    endtask

    initial begin
        seedDummy = $urandom(52);
        rst   = 1'b1;
        load  = '0;
        start = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        // second program reloads after done
        runProgram();
        runProgram();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== list.f ====
verilog/issuePkg.sv
verilog/instrFetch.sv
verilog/hazardDetect.sv
verilog/stageTracker.sv
verilog/retireUnit.sv
verilog/issueFrontEnd.sv
bench/hazardDetect_checker.sv
bench/issueFrontEnd_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module issueFrontEnd_tb -f list.f -o simv \
    && ./obj_dir/simv \
    || exit 1

// ==== verilog/hazardDetect.sv ====
`timescale 1ns/1ps
`default_nettype none
module hazardDetect (
    input  issuePkg::issueSlot_t  fetchSlot,
    input  issuePkg::hazardView_t hazardView,
    output issuePkg::issueSlot_t  issue,
    output logic                  stall
);
    import issuePkg::*;

    instWord_t              word;
    logic [opWidth-1:0]     op;
    logic [regIdxWidth-1:0] srcRs;
    logic [regIdxWidth-1:0] srcRt;
    logic                   useRs;
    logic                   useRt;
    logic                   rsHit;
    logic                   rtHit;
    logic                   dataHazard;
    logic                   ctrlHazard;

    // pending write to src in D, X or M
    // W is left out, the register file writes before it reads
    function automatic logic srcPending(
        input hazardView_t            view,
        input logic [regIdxWidth-1:0] src
    );
        logic hitD;
        logic hitX;
        logic hitM;
        hitD = view.d.regWrt && (view.d.wrtReg == src);
        hitX = view.x.regWrt && (view.x.wrtReg == src);
        hitM = view.m.regWrt && (view.m.wrtReg == src);
        return hitD || hitX || hitM;
    endfunction

    assign word  = fetchSlot.inst;
    assign op    = word.r.op;
    assign srcRs = word.r.rs;
    assign srcRt = word.r.rt;

    // which sources the fetched word reads
    always_comb begin
        // control forms and the default class read rs only
        useRs = 1'b1;
        useRt = 1'b0;
        if (isStoreOp(op) || isArithOp(op) || isSetOp(op)) begin
            // stores read the data reg in the rt slot
            useRt = 1'b1;
        end else if ((op == opLbi) || (op == opHalt) || (op == opNop)) begin
            // immediate load, halt, nop
            useRs = 1'b0;
        end
    end

    assign rsHit = useRs && srcPending(hazardView, srcRs);
    assign rtHit = useRt && srcPending(hazardView, srcRt);

    assign dataHazard = rsHit || rtHit;

    // nothing issues behind a control op still in flight
    assign ctrlHazard = hazardView.ctrlBusy;

    // no candidate means nothing to hold back
    assign stall = fetchSlot.valid && (dataHazard || ctrlHazard);

    // either the fetched word or a bubble
    always_comb begin
        issue.valid = fetchSlot.valid && !stall;
        issue.pc    = fetchSlot.pc;
        if (issue.valid) begin
            issue.inst = word;
        end else begin
            issue.inst = nopWord;
        end
    end

endmodule
`default_nettype wire

// ==== verilog/instrFetch.sv ====
`timescale 1ns/1ps
`default_nettype none
module instrFetch (
    input  logic                 clk,
    input  logic                 rst,
    input  issuePkg::loadReq_t   load,
    input  logic                 start,
    input  logic                 stall,
    input  issuePkg::issueSlot_t issue,
    input  issuePkg::redirect_t  redirect,
    output issuePkg::issueSlot_t fetchSlot
);
    import issuePkg::*;

    // program store
    logic [instWidth-1:0] mem [imemDepth];

    logic [addrWidth-1:0] pc;
    logic                 running;
    logic                 issuedHalt;
    logic                 loadOk;

    // loads only land while fetch is idle
    assign loadOk = load.valid && !running;

    // halt leaving fetch ends the run
    assign issuedHalt = issue.valid && (issue.inst.r.op == opHalt);

    // one word per strobe, same edge
    always_ff @(posedge clk) begin
        if (loadOk) begin
            mem[load.addr] <= load.data;
        end
    end

    // pc and run flag
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
        end else if (start && !running) begin
            // fresh run always begins at word 0
            pc      <= '0;
            running <= 1'b1;
        end else if (redirect.valid) begin
            // control leaving W, always taken
            pc <= redirect.target;
        end else if (issue.valid && !stall) begin
            pc <= pc + addrWidth'(1);
            if (issuedHalt) begin
                running <= 1'b0;
            end
        end
    end

    // candidate word, combinational read at pc
    // held word repeats while stalled
    always_comb begin
        fetchSlot.valid = running;
        fetchSlot.pc    = pc;
        fetchSlot.inst  = mem[pc];
    end

endmodule
`default_nettype wire

// ==== verilog/issueFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none
module issueFrontEnd (
    input  logic                          clk,
    input  logic                          rst,
    input  issuePkg::loadReq_t            load,
    input  logic                          start,
    output issuePkg::retireRec_t          retire,
    output logic [issuePkg::cntWidth-1:0] retiredCount,
    output logic                          done
);
    import issuePkg::*;

    issueSlot_t  fetchSlot;
    issueSlot_t  issue;
    logic        stall;
    hazardView_t hazardView;
    redirect_t   redirect;
    retireRec_t  wStage;

    // memory, pc, run flag
    instrFetch uFetch (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .start     (start),
        .stall     (stall),
        .issue     (issue),
        .redirect  (redirect),
        .fetchSlot (fetchSlot)
    );

    // issue or bubble
    hazardDetect uHazard (
        .fetchSlot  (fetchSlot),
        .hazardView (hazardView),
        .issue      (issue),
        .stall      (stall)
    );

    // D/X/M/W shadow pipe
    stageTracker uTracker (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .hazardView (hazardView),
        .redirect   (redirect),
        .wStage     (wStage)
    );

    retireUnit uRetire (
        .clk          (clk),
        .rst          (rst),
        .wStage       (wStage),
        .retire       (retire),
        .retiredCount (retiredCount),
        .done         (done)
    );

endmodule
`default_nettype wire

// ==== verilog/issuePkg.sv ====
package issuePkg;

    // datapath widths
    localparam int instWidth   = 16;
    localparam int imemDepth   = 256;
    localparam int addrWidth   = 8;
    localparam int regIdxWidth = 3;
    localparam int opWidth     = 5;
    localparam int dispWidth   = 8;
    localparam int cntWidth    = 16;

    // single opcodes
    localparam logic [opWidth-1:0] opHalt = 5'b00000;
    localparam logic [opWidth-1:0] opNop  = 5'b00001;
    localparam logic [opWidth-1:0] opLbi  = 5'b11000;
    localparam logic [opWidth-1:0] opSt   = 5'b10000;
    localparam logic [opWidth-1:0] opStu  = 5'b10011;

    // class prefixes, upper opcode bits only
    // arithmetic 1101x, set 111xx
    localparam logic [3:0] arithPrefix = 4'b1101;
    localparam logic [2:0] setPrefix   = 3'b111;
    // jumps 001xx, branches 011xx
    localparam logic [2:0] jmpPrefix   = 3'b001;
    localparam logic [2:0] brPrefix    = 3'b011;

    // bubble inserted on a stall
    localparam logic [instWidth-1:0] nopWord = {opNop, 11'b0};

    // register view, low two bits unused
    typedef struct packed {
        logic [opWidth-1:0]     op;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [regIdxWidth-1:0] rdLow;
        logic [1:0]             spare;
    } regForm_t;

    // control view with the 8-bit displacement
    typedef struct packed {
        logic [opWidth-1:0]     op;
        logic [regIdxWidth-1:0] rs;
        logic [dispWidth-1:0]   disp8;
    } ctrlForm_t;

    // same word, two decodes
    typedef union packed {
        regForm_t  r;
        ctrlForm_t c;
    } instWord_t;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] addr;
        logic [instWidth-1:0] data;
    } loadReq_t;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] pc;
        instWord_t            inst;
    } issueSlot_t;

    // one pending register write
    typedef struct packed {
        logic                   regWrt;
        logic [regIdxWidth-1:0] wrtReg;
    } writerInfo_t;

    typedef struct packed {
        writerInfo_t d;
        writerInfo_t x;
        writerInfo_t m;
        logic        ctrlBusy;
    } hazardView_t;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] pc;
        instWord_t            inst;
    } retireRec_t;

    // opcode class tests
    function automatic logic isStoreOp(input logic [opWidth-1:0] op);
        return (op == opSt) || (op == opStu);
    endfunction

    function automatic logic isArithOp(input logic [opWidth-1:0] op);
        return op[4:1] == arithPrefix;
    endfunction

    function automatic logic isSetOp(input logic [opWidth-1:0] op);
        return op[4:2] == setPrefix;
    endfunction

    function automatic logic isCtrlOp(input logic [opWidth-1:0] op);
        return (op[4:2] == jmpPrefix) || (op[4:2] == brPrefix);
    endfunction

endpackage

// ==== verilog/retireUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
module retireUnit (
    input  logic                          clk,
    input  logic                          rst,
    input  issuePkg::retireRec_t          wStage,
    output issuePkg::retireRec_t          retire,
    output logic [issuePkg::cntWidth-1:0] retiredCount,
    output logic                          done
);
    import issuePkg::*;

    logic [cntWidth-1:0] countReg;
    logic [cntWidth-1:0] baseCount;
    logic                finished;
    logic                isHalt;

    // retire strobe is the W cycle itself
    assign retire = wStage;

    assign isHalt = wStage.inst.r.op == opHalt;
    assign done   = wStage.valid && isHalt;

    // first retire of a new program restarts the count
    assign baseCount = (finished && wStage.valid) ? '0 : countReg;

    // count includes the one retiring now,
    // so the halt is already in it on done
    assign retiredCount = baseCount + cntWidth'(wStage.valid);

    // frozen between done and the next program
    always_ff @(posedge clk) begin
        if (rst) begin
            countReg <= '0;
            finished <= 1'b0;
        end else if (wStage.valid) begin
            countReg <= retiredCount;
            finished <= done;
        end
    end

endmodule
`default_nettype wire

// ==== verilog/stageTracker.sv ====
`timescale 1ns/1ps
`default_nettype none
module stageTracker (
    input  logic                  clk,
    input  logic                  rst,
    input  issuePkg::issueSlot_t  issue,
    output issuePkg::hazardView_t hazardView,
    output issuePkg::redirect_t   redirect,
    output issuePkg::retireRec_t  wStage
);
    import issuePkg::*;

    // shadow stages
    retireRec_t dRec;
    retireRec_t xRec;
    retireRec_t mRec;
    retireRec_t wRec;

    // pending writes, decoded once in D and carried along
    writerInfo_t dWr;
    writerInfo_t xWr;
    writerInfo_t mWr;

    logic [opWidth-1:0]   dOp;
    logic [instWidth-1:0] dispExt;
    logic [instWidth-1:0] targetFull;

    function automatic logic holdsCtrl(input retireRec_t rec);
        return rec.valid && isCtrlOp(rec.inst.c.op);
    endfunction

    assign dOp = dRec.inst.r.op;

    // destination decode
    always_comb begin
        // default class writes rt
        dWr.regWrt = dRec.valid;
        dWr.wrtReg = dRec.inst.r.rt;
        if (dOp == opLbi) begin
            dWr.wrtReg = dRec.inst.r.rs;
        end else if (isArithOp(dOp) || isSetOp(dOp)) begin
            dWr.wrtReg = dRec.inst.r.rdLow;
        end else if (isStoreOp(dOp) || isCtrlOp(dOp)) begin
            dWr.regWrt = 1'b0;
        end else if ((dOp == opHalt) || (dOp == opNop)) begin
            dWr.regWrt = 1'b0;
        end
    end

    // one cycle per stage, no back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            dRec.valid <= 1'b0;
            xRec.valid <= 1'b0;
            mRec.valid <= 1'b0;
            wRec.valid <= 1'b0;
            xWr.regWrt <= 1'b0;
            mWr.regWrt <= 1'b0;
        end else begin
            dRec <= retireRec_t'(issue);
            xRec <= dRec;
            mRec <= xRec;
            wRec <= mRec;
            xWr  <= dWr;
            mWr  <= xWr;
        end
    end

    // only D/X/M writers go back to the hazard check
    always_comb begin
        hazardView.d        = dWr;
        hazardView.x        = xWr;
        hazardView.m        = mWr;
        hazardView.ctrlBusy = holdsCtrl(dRec) || holdsCtrl(xRec)
                           || holdsCtrl(mRec) || holdsCtrl(wRec);
    end

    // sign-extended displacement
    assign dispExt = {{(instWidth-dispWidth){wRec.inst.c.disp8[dispWidth-1]}},
                      wRec.inst.c.disp8};

    // target is pc + 1 + disp, wraps within the memory
    assign targetFull = instWidth'(wRec.pc) + instWidth'(1) + dispExt;

    // taken unconditionally, fires for the W cycle only
    always_comb begin
        redirect.valid  = holdsCtrl(wRec);
        redirect.target = targetFull[addrWidth-1:0];
    end

    assign wStage = wRec;

endmodule
`default_nettype wire
